/* rename_vectors.txt */
// columns, one hex digit each: test, op, a, b, expected alloc_phys
// op 0 idle a cycles, 1 dispatch arch a mispredict b, 2 complete index a,
// 3 complete all outstanding (b 0 in order, 1 shuffled, 2 reversed), 4 ready a after b cycles
11008
11109
1120a
13000
21500
21501
23000
31100
31202
31305
3140b
33020
41003
41104
41209
4130a
4140c
4150d
4160e
4170f
44000
42000
44110
43000
51100
51211
51302
51405
53000
50400
51502
51604
53000
61705
61006
61707
61308
61209
6170b
63010

/* all.f */
rename_pkg.sv
free_list.sv
rename_stage.sv
reorder_buffer.sv
retire_rat.sv
rename_core.sv
rename_core_checker.sv
tb_rename_core.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - rename_pkg.sv
  - free_list.sv
  - rename_stage.sv
  - reorder_buffer.sv
  - retire_rat.sv
  - rename_core.sv
  - target: test
    files:
      - rename_core_checker.sv
      - tb_rename_core.sv

/* tb_rename_core.sv */
/*
 * Testbench for the rename and retirement block.
 * Operations come from rename_vectors.txt, one per line: dispatch,
 * completion, idle and ready checks, each with its expected result.
 * A reference model of both alias tables and the free list is updated
 * at every falling edge and checked against each grant and retirement.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

	localparam int rob_depth = 8;
	localparam int tag_w     = $clog2(rob_depth);
	localparam int max_lines = 64;

	typedef enum logic [3:0] {
		op_idle = 4'd0, op_dispatch = 4'd1, op_complete = 4'd2,
		op_complete_all = 4'd3, op_check_ready = 4'd4
	} op_t;

	// one vector line with a hex digit per field
	typedef struct packed {
		logic [3:0] test;
		op_t        op;
		logic [3:0] a;        // arch, index, cycles or level
		logic [3:0] b;        // mispredict, order or delay
		logic [3:0] exp_phys;
	} vector_t;

	logic                  clock;
	logic                  reset;
	logic                  dispatch_valid;
	rename_pkg::arch_idx_t dispatch_arch;
	logic                  dispatch_mispredict;
	logic                  complete_valid;
	logic [tag_w-1:0]      complete_tag;
	logic                  dispatch_ready;
	rename_pkg::phys_idx_t alloc_phys;
	logic [tag_w-1:0]      dispatch_tag;
	logic                  retire_valid;
	rename_pkg::arch_idx_t retire_arch;
	rename_pkg::phys_idx_t retire_phys;
	rename_pkg::phys_idx_t freed_phys;
	logic                  flush;

	logic [19:0]            vec_mem [max_lines];
	vector_t                cur_vec;
	int                     n_lines;
	int                     n_tests;
	int                     cur_test;
	int                     seed;
	int                     cycles;
	int                     cycle_limit;
	int                     errors [7];
	int                     total;
	int                     checker_fails;
	int                     n_disp;          // dispatches so far in this test
	logic [tag_w-1:0]       tag_of [16];
	logic                   done_flag [16];
	string                  test_name [7] = '{"setup", "lowest free grant",
		"freed register", "reverse completion", "full buffer", "mispredict flush",
		"shuffled mix"};

	rename_pkg::phys_map_t  model_committed;
	rename_pkg::phys_map_t  model_spec;
	logic [15:0]            model_free;      // 1 = free
	int                     model_tail;      // next tag the buffer hands out
	rename_pkg::rob_entry_t in_flight [$];   // dispatched entries in age order

	rename_core #(.rob_depth(rob_depth)) u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// watchdog
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	function automatic int lowest_free(input logic [15:0] v);
		for (int i = 0; i < 16; i++) begin
			if (v[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic logic is_mapped(input rename_pkg::phys_map_t m, input int p);
		for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
			if (m[i] == p) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic report_value(input string what, input int expected, input int actual);
		$display("error: test %0d (%s) %s expected %0d actual %0d",
			cur_test, test_name[cur_test], what, expected, actual);
		errors[cur_test]++;
	endtask

	task automatic note_failure(input string what);
		$display("test %0d (%s): %s", cur_test, test_name[cur_test], what);
		errors[cur_test]++;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1; // drive just after the edge
	endtask

	task automatic dispatch_one(input rename_pkg::arch_idx_t arch, input logic mis,
			input rename_pkg::phys_idx_t exp_phys);
		dispatch_valid      = 1'b1;
		dispatch_arch       = arch;
		dispatch_mispredict = mis;
		@(negedge clock);
		while (!dispatch_ready) begin // hold until accepted
			next_cycle();
			@(negedge clock);
		end
		assert (alloc_phys == exp_phys) else report_value("alloc_phys", exp_phys, alloc_phys);
		tag_of[n_disp]    = dispatch_tag;
		done_flag[n_disp] = 1'b0;
		n_disp++;
		next_cycle();
		dispatch_valid = 1'b0;
	endtask

	task automatic complete_one(input int idx);
		complete_valid = 1'b1;
		complete_tag   = tag_of[idx];
		done_flag[idx] = 1'b1;
		next_cycle();
		complete_valid = 1'b0;
	endtask

	// order 0 in order, 1 shuffled, 2 reversed, then wait for the drain
	task automatic complete_all(input logic [3:0] order);
		int pick [$];
		int j;
		int t;
		for (int i = 0; i < n_disp; i++) begin
			if (!done_flag[i]) begin
				pick.push_back(i);
			end
		end
		if (order == 4'd2) begin
			pick.reverse();
		end
		if (order == 4'd1) begin
			for (int i = pick.size() - 1; i > 0; i--) begin
				j       = $unsigned($random(seed)) % (i + 1);
				t       = pick[i];
				pick[i] = pick[j];
				pick[j] = t;
			end
		end
		foreach (pick[k]) begin
			complete_one(pick[k]);
		end
		while (in_flight.size() != 0) begin
			next_cycle();
		end
	endtask

	task automatic check_ready(input logic level, input logic [3:0] delay);
		repeat (delay) next_cycle();
		@(negedge clock);
		assert (dispatch_ready == level) else
			report_value("dispatch_ready", level, dispatch_ready);
		next_cycle();
	endtask

	task automatic run_vector(input vector_t v);
		case (v.op)
			op_idle:         repeat (v.a) next_cycle();
			op_dispatch:     dispatch_one(v.a[2:0], v.b[0], v.exp_phys);
			op_complete:     complete_one(v.a);
			op_complete_all: complete_all(v.b);
			op_check_ready:  check_ready(v.a[0], v.b);
			default:         note_failure("unknown operation code in the vector file");
		endcase
	endtask

	task automatic print_result(input int t);
		if (errors[t] == 0) begin
			$display("test %0d %s: ok", t, test_name[t]);
		end else begin
			$display("test %0d %s: %0d errors", t, test_name[t], errors[t]);
		end
	endtask

	//////////////////////////////////////////////////
	// reference model sampled mid-cycle
	//////////////////////////////////////////////////
	always @(negedge clock) begin : model_check
		int                     grant;
		rename_pkg::rob_entry_t oldest;
		rename_pkg::rob_entry_t entry;
		rename_pkg::phys_idx_t  old_phys;
		if (!reset) begin
			grant = lowest_free(model_free); // free set at start of cycle
			if (retire_valid) begin
				assert (in_flight.size() != 0) else
					note_failure("an instruction retired although none was outstanding");
				if (in_flight.size() != 0) begin
					oldest   = in_flight.pop_front();
					old_phys = model_committed[oldest.arch];
					assert (retire_arch == oldest.arch) else
						report_value("retire_arch", oldest.arch, retire_arch);
					assert (retire_phys == oldest.phys) else
						report_value("retire_phys", oldest.phys, retire_phys);
					assert (freed_phys == old_phys) else
						report_value("freed_phys", old_phys, freed_phys);
					assert (flush == oldest.mispredict) else
						report_value("flush", oldest.mispredict, flush);
					model_free[old_phys]         = 1'b1;
					model_committed[oldest.arch] = oldest.phys;
					if (oldest.mispredict) begin // younger work is dropped
						in_flight.delete();
						model_spec = model_committed;
						model_tail = 0;
						model_free = '1;
						for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
							model_free[model_committed[i]] = 1'b0;
						end
					end
				end
			end
			if (dispatch_valid && dispatch_ready) begin
				assert (grant >= 0) else note_failure("dispatch accepted with no free register");
				assert (alloc_phys == grant) else report_value("model grant", grant, alloc_phys);
				assert (!is_mapped(model_spec, alloc_phys) && !is_mapped(model_committed,
					alloc_phys)) else note_failure("granted register is still mapped");
				assert (dispatch_tag == model_tail) else
					report_value("dispatch_tag", model_tail, dispatch_tag);
				model_tail       = (model_tail + 1) % rob_depth;
				entry.arch       = dispatch_arch;
				entry.phys       = rename_pkg::phys_idx_t'(grant);
				entry.mispredict = dispatch_mispredict;
				in_flight.push_back(entry);
				model_free[entry.phys]    = 1'b0;
				model_spec[dispatch_arch] = entry.phys;
			end
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		seed                = 2;
		reset               = 1'b1;
		dispatch_valid      = 1'b0;
		dispatch_arch       = '0;
		dispatch_mispredict = 1'b0;
		complete_valid      = 1'b0;
		complete_tag        = '0;
		for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
			model_committed[i] = rename_pkg::phys_idx_t'(i); // arch i -> phys i
			model_spec[i]      = rename_pkg::phys_idx_t'(i);
		end
		model_free = 16'hff00;
		model_tail = 0;
		$readmemh("rename_vectors.txt", vec_mem);
		while (n_lines < max_lines && !$isunknown(vec_mem[n_lines])) begin
			n_lines++;
		end
		assert (n_lines > 0) else note_failure("no vectors were read from rename_vectors.txt");
		cycle_limit = 40 * n_lines + 16;
		repeat (16) @(posedge clock);
		#1 reset = 1'b0;
		for (int i = 0; i < n_lines; i++) begin
			cur_vec = vector_t'(vec_mem[i]);
			if (cur_vec.test != cur_test) begin // next test starts
				if (cur_test != 0) begin
					print_result(cur_test);
				end
				cur_test = cur_vec.test;
				n_disp   = 0;
				n_tests++;
			end
			run_vector(cur_vec);
		end
		print_result(cur_test);
		checker_fails = u_dut.u_checker.fail_count;
		assert (checker_fails == 0) else
			$display("bound checker saw %0d failed properties", checker_fails);
		total = checker_fails;
		foreach (errors[i]) begin
			total += errors[i];
		end
		$display("tests %0d, errors %0d", n_tests, total);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rename_core_checker.sv */
/*
 * Concurrent checks on the ports of the rename core.
 * Bound into rename_core below; watches flush, retirement and the
 * dispatch ready level on every rising clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_core_checker (
	input wire clock,
	input wire reset,
	input wire dispatch_ready,
	input wire retire_valid,
	input wire flush
);

	int fail_count = 0;

	// flush only comes from a retiring entry
	a_flush_retires: assert property (@(posedge clock) disable iff (reset)
		flush |-> retire_valid)
	else begin
		$error("flush raised without a retirement");
		fail_count++;
	end

	a_no_ready_in_flush: assert property (@(posedge clock) disable iff (reset)
		flush |-> !dispatch_ready) // rename blocked while tables reload
	else begin
		$error("dispatch_ready high during flush");
		fail_count++;
	end

	// buffer is empty right after reset
	a_quiet_after_reset: assert property (@(posedge clock) $fell(reset) |-> !retire_valid)
	else begin
		$error("retirement in the first cycle after reset");
		fail_count++;
	end

endmodule

bind rename_core rename_core_checker u_checker (
	.clock          (clock),
	.reset          (reset),
	.dispatch_ready (dispatch_ready),
	.retire_valid   (retire_valid),
	.flush          (flush)
);

`default_nettype wire

/* rename_core.sv */
/*
 * Top level of the rename and retirement block.
 * Rename stage feeds the reorder buffer, whose head drives the
 * retirement alias table; freed registers and flush go back to rename.
 * One dispatch and one retirement per cycle at most.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_core #(
	parameter int rob_depth = 8
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           dispatch_valid,
	input  rename_pkg::arch_idx_t         dispatch_arch,
	input  wire                           dispatch_mispredict,
	input  wire                           complete_valid,
	input  wire  [$clog2(rob_depth)-1:0]  complete_tag,
	output logic                          dispatch_ready,
	output rename_pkg::phys_idx_t         alloc_phys,
	output logic [$clog2(rob_depth)-1:0]  dispatch_tag,
	output logic                          retire_valid,
	output rename_pkg::arch_idx_t         retire_arch,
	output rename_pkg::phys_idx_t         retire_phys,
	output rename_pkg::phys_idx_t         freed_phys,
	output logic                          flush
);

	logic                   alloc;
	rename_pkg::rob_entry_t alloc_entry;  // rename -> buffer tail
	rename_pkg::retire_t    head;         // buffer head -> retirement
	rename_pkg::phys_map_t  committed_next;
	logic                   rob_full;
	logic                   freed_valid;

	//////////////////////////////////////////////////
	// producer, buffer, consumer
	//////////////////////////////////////////////////
	rename_stage u_rename_stage (
		.clock               (clock),
		.reset               (reset),
		.dispatch_valid      (dispatch_valid),
		.dispatch_arch       (dispatch_arch),
		.dispatch_mispredict (dispatch_mispredict),
		.rob_full            (rob_full),
		.freed_valid         (freed_valid),
		.freed_phys          (freed_phys),
		.flush               (flush),
		.committed_next      (committed_next),
		.dispatch_ready      (dispatch_ready),
		.alloc               (alloc),
		.alloc_entry         (alloc_entry)
	);

	reorder_buffer #(
		.rob_depth (rob_depth)
	) u_reorder_buffer (
		.clock          (clock),
		.reset          (reset),
		.alloc          (alloc),
		.alloc_entry    (alloc_entry),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.flush          (flush),
		.full           (rob_full),
		.tail_tag       (dispatch_tag),   // tag of the entry being dispatched
		.head           (head)
	);

	retire_rat u_retire_rat (
		.clock          (clock),
		.reset          (reset),
		.head           (head),
		.committed_next (committed_next),
		.freed_valid    (freed_valid),
		.freed_phys     (freed_phys),
		.flush          (flush)
	);

	// external views of the internal structs
	assign alloc_phys   = alloc_entry.phys;
	assign retire_valid = head.valid;
	assign retire_arch  = head.arch;
	assign retire_phys  = head.phys;

endmodule

`default_nettype wire

/* retire_rat.sv */
/*
 * Retirement alias table, the consumer side.
 * Holds the committed architectural to physical mapping. A valid head
 * commits its new mapping and releases the register the old committed
 * mapping held. A mispredicted head raises flush, and committed_next
 * then gives rename and the free list the state to restart from.
 */
`timescale 1ns/1ps
`default_nettype none

module retire_rat (
	input  wire                   clock,
	input  wire                   reset,
	input  rename_pkg::retire_t   head,
	output rename_pkg::phys_map_t committed_next,
	output logic                  freed_valid,
	output rename_pkg::phys_idx_t freed_phys,
	output logic                  flush
);

	rename_pkg::phys_map_t committed; // architectural state

	//////////////////////////////////////////////////
	// retirement decode
	//////////////////////////////////////////////////
	assign freed_valid = head.valid;
	assign freed_phys  = committed[head.arch]; // previous owner of arch reg
	assign flush       = head.valid & head.mispredict;

	// committed map with this cycle's retiring write applied
	always_comb begin
		committed_next = committed;
		if (head.valid) begin
			committed_next[head.arch] = head.phys;
		end
	end

	//////////////////////////////////////////////////
	// committed table
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			committed <= rename_pkg::identity_map(); // arch i -> phys i
		end else begin
			committed <= committed_next; // unchanged when no retirement
		end
	end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
/*
 * Reorder buffer.
 * Circular array of renamed entries kept in program order. A completion
 * strobe marks a pending slot done by tag; the head is presented for
 * retirement as soon as it is done and leaves in the same cycle.
 * Flush empties every slot and returns the pointers to zero.
 */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
	parameter int rob_depth = 8
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           alloc,
	input  rename_pkg::rob_entry_t        alloc_entry,
	input  wire                           complete_valid,
	input  wire  [$clog2(rob_depth)-1:0]  complete_tag,
	input  wire                           flush,
	output logic                          full,
	output logic [$clog2(rob_depth)-1:0]  tail_tag,
	output rename_pkg::retire_t           head
);

	localparam int tag_w = $clog2(rob_depth);

	rename_pkg::entry_state_t state   [rob_depth]; // per-slot state
	rename_pkg::rob_entry_t   entries [rob_depth]; // payload
	logic [tag_w-1:0]         head_ptr;
	logic [tag_w-1:0]         tail_ptr;
	logic [tag_w:0]           count;
	logic                     pop;

	// wrap-around increment, depth need not be a power of two
	function automatic logic [tag_w-1:0] next_ptr(input logic [tag_w-1:0] p);
		logic [tag_w-1:0] n;
		n = (p == tag_w'(rob_depth - 1)) ? '0 : p + 1'b1;
		return n;
	endfunction

	//////////////////////////////////////////////////
	// head presentation
	//////////////////////////////////////////////////
	always_comb begin
		head.valid      = (state[head_ptr] == rename_pkg::done);
		head.arch       = entries[head_ptr].arch;
		head.phys       = entries[head_ptr].phys;
		head.mispredict = entries[head_ptr].mispredict;
	end

	assign pop      = head.valid; // retirement never stalls
	assign full     = (count == (tag_w + 1)'(rob_depth));
	assign tail_tag = tail_ptr;

	//////////////////////////////////////////////////
	// slot state and pointers
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			for (int i = 0; i < rob_depth; i++) begin
				state[i] <= rename_pkg::empty;
			end
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			// only a pending slot may complete, stale tags hit empty slots
			if (complete_valid && state[complete_tag] == rename_pkg::pending) begin
				state[complete_tag] <= rename_pkg::done;
			end
			if (alloc) begin
				state[tail_ptr] <= rename_pkg::pending;
				tail_ptr        <= next_ptr(tail_ptr);
			end
			if (pop) begin
				state[head_ptr] <= rename_pkg::empty;
				head_ptr        <= next_ptr(head_ptr);
			end
			count <= count + alloc - pop; // both may happen in one cycle
		end
	end

	// payload written at the tail only
	always_ff @(posedge clock) begin
		if (alloc) begin
			entries[tail_ptr] <= alloc_entry;
		end
	end

endmodule

`default_nettype wire

/* rename_stage.sv */
/*
 * Rename stage, the producer side.
 * Maps the destination of each dispatched instruction to a free physical
 * register, records it in the speculative alias table and hands an entry
 * to the reorder buffer. A flush reloads the table from the committed map.
 */
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    dispatch_valid,
	input  rename_pkg::arch_idx_t  dispatch_arch,
	input  wire                    dispatch_mispredict,
	input  wire                    rob_full,
	input  wire                    freed_valid,
	input  rename_pkg::phys_idx_t  freed_phys,
	input  wire                    flush,
	input  rename_pkg::phys_map_t  committed_next,
	output logic                   dispatch_ready,
	output logic                   alloc,
	output rename_pkg::rob_entry_t alloc_entry
);

	rename_pkg::phys_map_t spec_map; // speculative alias table
	logic                  grant_valid;
	rename_pkg::phys_idx_t grant_phys;

	//////////////////////////////////////////////////
	// free register source
	//////////////////////////////////////////////////
	free_list u_free_list (
		.clock          (clock),
		.reset          (reset),
		.take           (alloc),
		.freed_valid    (freed_valid),
		.freed_phys     (freed_phys),
		.flush          (flush),
		.committed_next (committed_next),
		.grant_valid    (grant_valid),
		.grant_phys     (grant_phys)
	);

	// the only back-pressure, no free reg, full buffer or flush in progress
	assign dispatch_ready = grant_valid & ~rob_full & ~flush;
	assign alloc          = dispatch_valid & dispatch_ready;

	// entry for the buffer tail, phys is valid in the accepting cycle
	always_comb begin
		alloc_entry.arch       = dispatch_arch;
		alloc_entry.phys       = grant_phys;
		alloc_entry.mispredict = dispatch_mispredict;
	end

	//////////////////////////////////////////////////
	// speculative alias table
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			spec_map <= rename_pkg::identity_map();
		end else if (flush) begin
			spec_map <= committed_next; // drop all younger renames
		end else if (alloc) begin
			spec_map[dispatch_arch] <= grant_phys;
		end
	end

endmodule

`default_nettype wire

/* free_list.sv */
/*
 * Physical register free list.
 * One bit per physical register, set while the register is free.
 * Grants the lowest free register, clears it on take, sets a freed one
 * on retirement, and on flush rebuilds from the committed mapping.
 */
`timescale 1ns/1ps
`default_nettype none

module free_list (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   take,           // granted reg consumed this cycle
	input  wire                   freed_valid,
	input  rename_pkg::phys_idx_t freed_phys,
	input  wire                   flush,
	input  rename_pkg::phys_map_t committed_next, // committed map incl. retiring write
	output logic                  grant_valid,
	output rename_pkg::phys_idx_t grant_phys
);

	logic [rename_pkg::num_phys_regs-1:0] free_vec; // 1 = free
	logic [rename_pkg::num_phys_regs-1:0] mapped;   // regs named by committed_next

	//////////////////////////////////////////////////
	// lowest-set-bit priority encoder
	//////////////////////////////////////////////////
	always_comb begin
		grant_valid = 1'b0;
		grant_phys  = '0;
		// walk downward so the lowest free bit is the last one written
		for (int i = rename_pkg::num_phys_regs - 1; i >= 0; i--) begin
			if (free_vec[i]) begin
				grant_valid = 1'b1;
				grant_phys  = rename_pkg::phys_idx_t'(i);
			end
		end
	end

	// decode committed mapping into a used-register mask
	always_comb begin
		mapped = '0;
		for (int a = 0; a < rename_pkg::num_arch_regs; a++) begin
			mapped[committed_next[a]] = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// free vector update
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			// regs 0..7 hold the identity mapping, the rest start free
			for (int i = 0; i < rename_pkg::num_phys_regs; i++) begin
				free_vec[i] <= (i >= rename_pkg::num_arch_regs);
			end
		end else if (flush) begin
			free_vec <= ~mapped; // everything not committed is free again
		end else begin
			// take and free never hit the same bit, a freed reg is mapped
			if (take) begin
				free_vec[grant_phys] <= 1'b0;
			end
			if (freed_valid) begin
				free_vec[freed_phys] <= 1'b1; // grantable next cycle
			end
		end
	end

endmodule

`default_nettype wire

/* rename_pkg.sv */
/*
 * Shared types for the rename and retirement block.
 * Register counts, index widths, reorder-buffer slot state and the
 * structs that pass between rename, reorder buffer and retirement table.
 * Modules reach these through rename_pkg:: scoped names.
 */
`default_nettype none

package rename_pkg;

	//////////////////////////////////////////////////
	// register file sizes
	//////////////////////////////////////////////////
	localparam int num_arch_regs = 8;
	localparam int num_phys_regs = 16;

	typedef logic [$clog2(num_arch_regs)-1:0] arch_idx_t; // 3 bits
	typedef logic [$clog2(num_phys_regs)-1:0] phys_idx_t; // 4 bits

	// reorder buffer slot state
	typedef enum logic [1:0] {
		empty   = 2'd0,
		pending = 2'd1, // dispatched, waiting on completion
		done    = 2'd2  // completed, may retire
	} entry_state_t;

	// rename stage -> reorder buffer, 8 bits
	typedef struct packed {
		arch_idx_t arch;
		phys_idx_t phys;       // newly allocated register
		logic      mispredict;
	} rob_entry_t;

	// reorder buffer head -> retirement table, 9 bits
	typedef struct packed {
		logic      valid;
		arch_idx_t arch;
		phys_idx_t phys;       // new mapping to commit
		logic      mispredict;
	} retire_t;

	// whole alias table, arch reg i in slot i, 32 bits
	typedef phys_idx_t [num_arch_regs-1:0] phys_map_t;

	// power-up mapping, arch i -> phys i
	function automatic phys_map_t identity_map();
		phys_map_t m;
		for (int i = 0; i < num_arch_regs; i++) begin
			m[i] = phys_idx_t'(i);
		end
		return m;
	endfunction

endpackage

`default_nettype wire
